/* verilog/ct_macros.svh */
`ifndef CT_MACROS_SVH
`define CT_MACROS_SVH

// Flit and head field widths
`define CT_FLIT_W 16
`define CT_DEST_W 2
`define CT_LEN_W 4
`define CT_TAG_W 10

// Link channels multiplexed over the tunnel
`define CT_NUM_CH 3

// Shared flit buffer
`define CT_FIFO_DEPTH 8

`endif

/* verilog/ct_pkg.sv */
`include "ct_macros.svh"

package ct_pkg;

  // Channel index that also sets the width of the head dest field
  typedef logic [`CT_DEST_W-1:0] ct_ch_t;

  // Head flit layout with dest in the top bits
  typedef struct packed
  {
    ct_ch_t               dest;
    logic [`CT_LEN_W-1:0] len;
    logic [`CT_TAG_W-1:0] tag;
  } ct_head_s;

  // One flit word read as raw payload or as a head
  typedef union packed
  {
    logic [`CT_FLIT_W-1:0] raw;
    ct_head_s              head;
  } ct_flit_u;

endpackage

/* verilog/ct_flit_link_if.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

interface ct_flit_link_if;
  import ct_pkg::*;

  logic     v;
  logic     ready_and;
  ct_flit_u flit;
  // Marks the final flit of a packet
  logic     last;

  modport sender
  (
    output v,
    output flit,
    output last,
    input  ready_and
  );

  modport receiver
  (
    input  v,
    input  flit,
    input  last,
    output ready_and
  );

endinterface

/* verilog/ct_packet_arbiter.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

module ct_packet_arbiter
(
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [`CT_NUM_CH-1:0]                in_v_i,
  input  ct_pkg::ct_flit_u [`CT_NUM_CH-1:0]    in_flit_i,
  output logic [`CT_NUM_CH-1:0]                in_ready_o,
  ct_flit_link_if.sender                       link_o
);
  import ct_pkg::*;

  // Packet lock state
  logic                 locked_r;
  ct_ch_t               grant_r;
  logic [`CT_LEN_W-1:0] remain_r;

  // Output register
  logic     out_v_r;
  ct_flit_u out_flit_r;
  logic     out_last_r;

  logic     rr_found;
  ct_ch_t   rr_ch;
  ct_ch_t   sel_ch;
  logic     sel_v;
  ct_flit_u sel_flit;
  logic     can_load;
  logic     accept;
  logic     last_now;

  ////////////////////////////////////////////////////////////
  // Round-robin search starting after the last grant
  ////////////////////////////////////////////////////////////

  always_comb
  begin : rr_search
    int unsigned idx;
    rr_found = 1'b0;
    rr_ch    = '0;
    for (int i = 1; i <= `CT_NUM_CH; i++)
    begin
      idx = (int'(grant_r) + i) % `CT_NUM_CH;
      if (!rr_found && in_v_i[idx])
      begin
        rr_found = 1'b1;
        rr_ch    = ct_ch_t'(idx);
      end
    end
  end

  assign sel_ch   = locked_r ? grant_r : rr_ch;
  assign sel_v    = locked_r ? in_v_i[sel_ch] : rr_found;
  assign sel_flit = in_flit_i[sel_ch];

  // Register is free or drains this cycle
  assign can_load = !out_v_r || link_o.ready_and;
  assign accept   = sel_v && can_load;

  // Head with no body is its own last flit
  assign last_now = locked_r ? (remain_r == `CT_LEN_W'(1)) : (sel_flit.head.len == '0);

  always_comb
  begin
    in_ready_o = '0;
    if (locked_r || rr_found)
      in_ready_o[sel_ch] = can_load;
  end

  ////////////////////////////////////////////////////////////
  // Grant and body count
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      locked_r <= 1'b0;
      grant_r  <= ct_ch_t'(`CT_NUM_CH - 1);
      remain_r <= '0;
    end
    else if (accept)
    begin
      if (!locked_r)
      begin
        grant_r <= rr_ch;
        if (sel_flit.head.len != '0)
        begin
          locked_r <= 1'b1;
          remain_r <= sel_flit.head.len;
        end
      end
      else
      begin
        remain_r <= remain_r - `CT_LEN_W'(1);
        if (last_now)
          locked_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      out_v_r <= 1'b0;
    else if (can_load)
      out_v_r <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      out_flit_r <= sel_flit;
      out_last_r <= last_now;
    end
  end

  assign link_o.v    = out_v_r;
  assign link_o.flit = out_flit_r;
  assign link_o.last = out_last_r;

  // Demux downstream can only route to existing channels
  a_head_dest: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (accept && !locked_r) |-> (int'(sel_flit.head.dest) < `CT_NUM_CH));

endmodule

/* verilog/ct_flit_fifo.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

module ct_flit_fifo
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  ct_flit_link_if.receiver  wr_link_i,
  ct_flit_link_if.sender    rd_link_o
);

  localparam int PTR_W = $clog2(`CT_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`CT_FIFO_DEPTH + 1);

  // Each entry keeps last on top of the flit
  logic [`CT_FLIT_W:0] mem_r [`CT_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             wr_en;
  logic             rd_en;

  assign wr_link_i.ready_and = (count_r != CNT_W'(`CT_FIFO_DEPTH));
  assign wr_en               = wr_link_i.v && wr_link_i.ready_and;

  assign rd_link_o.v    = (count_r != '0);
  assign rd_link_o.flit = mem_r[rd_ptr_r][`CT_FLIT_W-1:0];
  assign rd_link_o.last = mem_r[rd_ptr_r][`CT_FLIT_W];
  assign rd_en          = rd_link_o.v && rd_link_o.ready_and;

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem_r[wr_ptr_r] <= {wr_link_i.last, wr_link_i.flit};
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_r <= (wr_ptr_r == PTR_W'(`CT_FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + PTR_W'(1);
      if (rd_en)
        rd_ptr_r <= (rd_ptr_r == PTR_W'(`CT_FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + PTR_W'(1);
      if (wr_en && !rd_en)
        count_r <= count_r + CNT_W'(1);
      else if (rd_en && !wr_en)
        count_r <= count_r - CNT_W'(1);
    end
  end

  a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_r <= CNT_W'(`CT_FIFO_DEPTH));

  // Pointers must show stored data on every read
  a_no_empty_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_en |-> ((rd_ptr_r != wr_ptr_r) || (count_r == CNT_W'(`CT_FIFO_DEPTH))));

endmodule

/* verilog/ct_packet_demux.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

module ct_packet_demux
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  ct_flit_link_if.receiver                  link_i,
  output logic [`CT_NUM_CH-1:0]             out_v_o,
  output ct_pkg::ct_flit_u [`CT_NUM_CH-1:0] out_flit_o,
  input  logic [`CT_NUM_CH-1:0]             out_ready_i
);
  import ct_pkg::*;

  logic                 busy_r;
  ct_ch_t               route_r;
  ct_ch_t               route;
  logic [`CT_NUM_CH-1:0] route_mask;
  logic                 xfer;

  ////////////////////////////////////////////////////////////
  // Route select
  ////////////////////////////////////////////////////////////

  // Idle means the link carries a head
  assign route = busy_r ? route_r : link_i.flit.head.dest;

  always_comb
  begin
    route_mask = '0;
    for (int i = 0; i < `CT_NUM_CH; i++)
    begin
      if (route == ct_ch_t'(i))
        route_mask[i] = 1'b1;
    end
  end

  always_comb
  begin
    for (int i = 0; i < `CT_NUM_CH; i++)
    begin
      out_v_o[i]    = link_i.v && route_mask[i];
      out_flit_o[i] = link_i.flit;
    end
  end

  // Back-pressure comes only from the selected output
  assign link_i.ready_and = |(route_mask & out_ready_i);
  assign xfer             = link_i.v && link_i.ready_and;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r  <= 1'b0;
      route_r <= '0;
    end
    else if (xfer)
    begin
      busy_r  <= !link_i.last;
      route_r <= route;
    end
  end

  // Only the channel picked by the head may see valid mid-packet
  a_no_stray_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (xfer && !link_i.last) |=> ((out_v_o & ~$past(route_mask)) == '0));

endmodule

/* verilog/ct_tunnel_top.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

module ct_tunnel_top
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  // Input link channels
  input  logic [`CT_NUM_CH-1:0]             in_v_i,
  input  ct_pkg::ct_flit_u [`CT_NUM_CH-1:0] in_flit_i,
  output logic [`CT_NUM_CH-1:0]             in_ready_o,

  // Output link channels
  output logic [`CT_NUM_CH-1:0]             out_v_o,
  output ct_pkg::ct_flit_u [`CT_NUM_CH-1:0] out_flit_o,
  input  logic [`CT_NUM_CH-1:0]             out_ready_i
);

  ////////////////////////////////////////////////////////////
  // Shared link from arbiter to FIFO to demux
  ////////////////////////////////////////////////////////////

  ct_flit_link_if arb_link ();
  ct_flit_link_if fifo_link ();

  ct_packet_arbiter u_arb
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_v_i     (in_v_i),
    .in_flit_i  (in_flit_i),
    .in_ready_o (in_ready_o),
    .link_o     (arb_link.sender)
  );

  ct_flit_fifo u_fifo
  (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_link_i (arb_link.receiver),
    .rd_link_o (fifo_link.sender)
  );

  ct_packet_demux u_demux
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .link_i      (fifo_link.receiver),
    .out_v_o     (out_v_o),
    .out_flit_o  (out_flit_o),
    .out_ready_i (out_ready_i)
  );

endmodule

/* test/tb_ct_checks.svh */
`ifndef TB_CT_CHECKS_SVH
`define TB_CT_CHECKS_SVH

// Head layout from the top down is dest, len, tag
function automatic ct_ch_t expected_dest(input ct_flit_u flit, output int unsigned body_cnt);
  body_cnt = flit.raw[`CT_FLIT_W-`CT_DEST_W-1 -: `CT_LEN_W];
  return flit.raw[`CT_FLIT_W-1 -: `CT_DEST_W];
endfunction

task automatic check_flit(input string name, input ct_flit_u got, input ct_flit_u exp);
  if (got !== exp)
    fail_stop($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got.raw, exp.raw));
endtask

task automatic check_channel(input string name, input ct_ch_t got, input ct_ch_t exp);
  if (got !== exp)
    fail_stop($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_valid
(
  input string                 name,
  input logic [`CT_NUM_CH-1:0] got,
  input logic [`CT_NUM_CH-1:0] exp
);
  if (got !== exp)
    fail_stop($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
endtask

`endif

/* test/tb_ct_tunnel.sv */
`timescale 1ns/100ps

`include "ct_macros.svh"

module tb_ct_tunnel;
  import ct_pkg::*;

  localparam int TIMEOUT   = 2000;
  localparam int PKT_COUNT = 12;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [`CT_NUM_CH-1:0]     in_v_i;
  ct_flit_u [`CT_NUM_CH-1:0] in_flit_i;
  logic [`CT_NUM_CH-1:0]     in_ready_o;
  logic [`CT_NUM_CH-1:0]     out_v_o;
  ct_flit_u [`CT_NUM_CH-1:0] out_flit_o;
  logic [`CT_NUM_CH-1:0]     out_ready_i;

  int          seed;
  logic        bp_on;
  ct_flit_u    tx_q [`CT_NUM_CH][$];
  // Expected flits in slot source * CT_NUM_CH + output
  ct_flit_u    exp_q [`CT_NUM_CH*`CT_NUM_CH][$];
  int unsigned rem [`CT_NUM_CH];
  int unsigned cur_src [`CT_NUM_CH];

  ct_tunnel_top i_dut
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_v_i      (in_v_i),
    .in_flit_i   (in_flit_i),
    .in_ready_o  (in_ready_o),
    .out_v_o     (out_v_o),
    .out_flit_o  (out_flit_o),
    .out_ready_i (out_ready_i)
  );

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  `include "tb_ct_checks.svh"

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Tag keeps the source in its low bits and the sequence number above
  task automatic build_packets(input int src, input int count, input int seq_base);
    ct_flit_u head;
    ct_flit_u body;
    ct_ch_t   dest;
    dest = '0;
    for (int k = 0; k < count; k++)
    begin
      // Every zero-length packet is followed by one to the same output
      if (k % 4 != 1)
        dest = ct_ch_t'($unsigned($random(seed)) % `CT_NUM_CH);
      head.head.dest = dest;
      head.head.len  = (k % 4 == 0) ? '0 : `CT_LEN_W'($random(seed));
      head.head.tag  = `CT_TAG_W'(((seq_base + k) << 2) | src);
      tx_q[src].push_back(head);
      exp_q[src * `CT_NUM_CH + dest].push_back(head);
      for (int b = 0; b < head.head.len; b++)
      begin
        body.raw = `CT_FLIT_W'($random(seed));
        tx_q[src].push_back(body);
        exp_q[src * `CT_NUM_CH + dest].push_back(body);
      end
    end
  endtask

  // Called just after a rising edge and returns on the edge of the transfer
  task automatic send_flit(input int ch, input ct_flit_u f);
    int cycles;
    cycles = 0;
    in_v_i[ch]    <= 1'b1;
    in_flit_i[ch] <= f;
    do
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT)
        fail_stop($sformatf("Input %0d did not accept a flit in time", ch));
    end
    while (!in_ready_o[ch]);
    @(posedge clk_i);
  endtask

  task automatic drive_channel(input int ch);
    ct_flit_u f;
    while (tx_q[ch].size() != 0)
    begin
      f = tx_q[ch].pop_front();
      send_flit(ch, f);
    end
    in_v_i[ch] <= 1'b0;
  endtask

  task automatic toggle_ready();
    int cycles;
    cycles = 0;
    while (bp_on)
    begin
      out_ready_i <= `CT_NUM_CH'($random(seed));
      @(posedge clk_i);
      cycles++;
      if (cycles > 20 * TIMEOUT)
        fail_stop("The back-pressure phase did not finish in time");
    end
    out_ready_i <= '1;
  endtask

  function automatic int pending_flits();
    int total;
    total = 0;
    for (int i = 0; i < `CT_NUM_CH * `CT_NUM_CH; i++)
      total += exp_q[i].size();
    return total;
  endfunction

  task automatic wait_drain(input string phase);
    int cycles;
    cycles = 0;
    while (pending_flits() != 0)
    begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT)
        fail_stop($sformatf("Not all packets of the %s phase were delivered", phase));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard sampled mid-cycle where outputs are settled
  ////////////////////////////////////////////////////////////

  initial
  begin : scoreboard
    ct_flit_u    got;
    ct_flit_u    exp;
    ct_ch_t      dest;
    int unsigned body;
    int unsigned qi;
    forever
    begin
      @(negedge clk_i);
      for (int ch = 0; ch < `CT_NUM_CH; ch++)
      begin
        if (rst_n_i && out_v_o[ch] && out_ready_i[ch])
        begin
          got = out_flit_o[ch];
          if (rem[ch] == 0)
          begin
            dest = expected_dest(got, body);
            check_channel($sformatf("out_v_o[%0d] channel", ch), ct_ch_t'(ch), dest);
            cur_src[ch] = got.head.tag[1:0];
            rem[ch]     = body;
          end
          else
            rem[ch]--;
          qi = cur_src[ch] * `CT_NUM_CH + ch;
          if (cur_src[ch] >= `CT_NUM_CH || exp_q[qi].size() == 0)
            fail_stop($sformatf("Output %0d delivered a flit that was never sent", ch));
          exp = exp_q[qi].pop_front();
          check_flit($sformatf("out_flit_o[%0d]", ch), got, exp);
        end
      end
    end
  end

  initial
  begin : stimulus
    seed        = 32'hc0b3_6791;
    bp_on       = 1'b0;
    rst_n_i     = 1'b0;
    in_v_i      = '0;
    in_flit_i   = '0;
    out_ready_i = '1;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Idle tunnel
    repeat (4)
    begin
      @(negedge clk_i);
      check_valid("out_v_o", out_v_o, '0);
      check_valid("in_ready_o", in_ready_o, '0);
    end

    // All outputs ready and all inputs busy at once
    for (int ch = 0; ch < `CT_NUM_CH; ch++)
      build_packets(ch, PKT_COUNT, 0);
    @(posedge clk_i);
    fork
      drive_channel(0);
      drive_channel(1);
      drive_channel(2);
    join
    wait_drain("all-ready");

    // Random back-pressure on the outputs
    for (int ch = 0; ch < `CT_NUM_CH; ch++)
      build_packets(ch, PKT_COUNT, PKT_COUNT);
    bp_on = 1'b1;
    @(posedge clk_i);
    fork
      begin
        fork
          drive_channel(0);
          drive_channel(1);
          drive_channel(2);
        join
        bp_on = 1'b0;
      end
      toggle_ready();
    join
    wait_drain("back-pressure");

    // Nothing more may come out once every queue is empty
    repeat (4)
    begin
      @(negedge clk_i);
      check_valid("out_v_o", out_v_o, '0);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
+incdir+test
verilog/ct_pkg.sv
verilog/ct_flit_link_if.sv
verilog/ct_packet_arbiter.sv
verilog/ct_flit_fifo.sv
verilog/ct_packet_demux.sv
verilog/ct_tunnel_top.sv
test/tb_ct_tunnel.sv
